// File: sram_proc.f
rtl/sram_proc_pkg.sv
rtl/sram_word_engine.sv
rtl/crc32_scanner.sv
rtl/sram_cmd_ctrl.sv
rtl/sram_proc.sv
verification/sram_drv_model.sv
verification/tb_sram_proc.sv

// File: verification/tb_sram_proc.sv
`timescale 1ns/1ps

module tb_sram_proc import sram_proc_pkg::*; ();

    localparam int ADDR_W  = 19;
    // Cycle limit for any single wait
    localparam int TIMEOUT = 2000;

    logic              clk;
    logic              resetn;
    logic              start;
    cmd_e              cmd;
    word_t             addr_in;
    word_t             data_in;
    strb_t             mem_wstrb;
    logic              busy;
    logic              done;
    word_t             result;
    logic              sram_valid;
    logic              sram_we;
    logic [ADDR_W-1:0] sram_addr;
    half_t             sram_wdata;
    logic              sram_ready;
    half_t             sram_rdata;

    // Shadow memory by word index and the result expected at the next done
    word_t shadow [0:2047];
    word_t exp_result;

    sram_proc #(.SRAM_ADDR_W(ADDR_W)) UUT (.*);

    sram_drv_model #(.ADDR_W(ADDR_W)) u_sram_drv (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // One-cycle start pulse that returns just after the accepting edge
    task automatic issue(input cmd_e c, input word_t a, input word_t d, input strb_t s);
        start     = 1'b1;
        cmd       = c;
        addr_in   = a;
        data_in   = d;
        mem_wstrb = s;
        next_cycle();
        start = 1'b0;
    endtask

    task automatic wait_done(input string what);
        int n;
        n = 0;
        while (!done && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (!done) abort_run({"timeout waiting for done of ", what});
    endtask

    // Byte lanes with strobe set take the new data
    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input strb_t s);
        word_t w;
        w = old_w;
        for (int i = 0; i < 4; i++) begin
            if (s[i]) w[8*i +: 8] = new_w[8*i +: 8];
        end
        return w;
    endfunction

    // Reference CRC over at least one word, stopping once the next address reaches last
    function automatic word_t ref_crc(input word_t first, input word_t last);
        word_t c;
        word_t a;
        c = CRC32_INIT;
        a = first;
        do begin
            c = crc32_word(c, shadow[a[12:2]]);
            a = a + 32'd4;
        end while (a < last);
        return ~c;
    endfunction

    task automatic do_write(input word_t a, input word_t d, input strb_t s);
        shadow[a[12:2]] = merge_bytes(shadow[a[12:2]], d, s);
        exp_result = '0;
        issue(CMD_WRITE, a, d, s);
        wait_done("write");
        next_cycle();
    endtask

    task automatic do_read(input word_t a);
        exp_result = shadow[a[12:2]];
        issue(CMD_READ, a, '0, '0);
        wait_done("read");
        next_cycle();
    endtask

    task automatic do_crc(input word_t first, input word_t last);
        exp_result = ref_crc(first, last);
        issue(CMD_CRC, first, last, '0);
        wait_done("CRC");
        next_cycle();
    endtask

    // ======================================================================
    // Checks
    // ======================================================================
    a_reset_idle: assert property (@(posedge clk)
        $rose(resetn) |-> !busy && !done && !sram_valid && !sram_we && result == '0)
        else abort_run($sformatf(
            "error: after reset busy=%h done=%h sram_valid=%h sram_we=%h result=%h",
            $sampled(busy), $sampled(done), $sampled(sram_valid), $sampled(sram_we),
            $sampled(result)));

    a_result: assert property (@(posedge clk) disable iff (!resetn)
        done |-> result == exp_result)
        else abort_run($sformatf("error: result = %h, expected %h",
            $sampled(result), $sampled(exp_result)));

    // Access frozen until ready
    a_addr_hold: assert property (@(posedge clk) disable iff (!resetn)
        sram_valid && !sram_ready |=> $stable(sram_addr))
        else abort_run($sformatf("error: sram_addr = %h, held value was %h",
            $sampled(sram_addr), $past(sram_addr)));

    a_we_hold: assert property (@(posedge clk) disable iff (!resetn)
        sram_valid && !sram_ready |=> $stable(sram_we))
        else abort_run($sformatf("error: sram_we = %h, held value was %h",
            $sampled(sram_we), $past(sram_we)));

    a_wdata_hold: assert property (@(posedge clk) disable iff (!resetn)
        sram_valid && !sram_ready |=> $stable(sram_wdata))
        else abort_run($sformatf("error: sram_wdata = %h, held value was %h",
            $sampled(sram_wdata), $past(sram_wdata)));

    a_valid_gap: assert property (@(posedge clk) disable iff (!resetn)
        sram_valid && sram_ready |=> !sram_valid)
        else abort_run($sformatf(
            "error: sram_valid = %h in the cycle after sram_ready, expected 0",
            $sampled(sram_valid)));

    a_unknown_done: assert property (@(posedge clk) disable iff (!resetn)
        start && !busy && !(cmd inside {CMD_READ, CMD_WRITE, CMD_CRC})
            |=> done && !sram_valid && $stable(result))
        else abort_run({"unknown command did not finish one cycle after start ",
            "without an access"});

    a_known_busy: assert property (@(posedge clk) disable iff (!resetn)
        start && !busy && (cmd inside {CMD_READ, CMD_WRITE, CMD_CRC}) |=> busy)
        else abort_run($sformatf("error: busy = %h after an accepted start, expected 1",
            $sampled(busy)));

    a_done_pulse: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done)
        else abort_run($sformatf("error: done = %h in the cycle after a done pulse, expected 0",
            $sampled(done)));

    a_done_busy: assert property (@(posedge clk) disable iff (!resetn)
        done |-> !busy)
        else abort_run($sformatf("error: busy = %h in the done cycle, expected 0",
            $sampled(busy)));

    a_busy_fall: assert property (@(posedge clk) disable iff (!resetn)
        $fell(busy) |-> done)
        else abort_run($sformatf("error: done = %h when busy fell, expected 1", $sampled(done)));

    // ======================================================================
    // Stimulus
    // ======================================================================
    initial begin
        word_t a;
        void'($urandom(32'h958));
        resetn     = 1'b0;
        start      = 1'b0;
        cmd        = CMD_NONE;
        addr_in    = '0;
        data_in    = '0;
        mem_wstrb  = '0;
        exp_result = '0;
        repeat (3) @(posedge clk);
        #1;
        resetn = 1'b1;
        next_cycle();

        // Mirror the model's fill with the low half-word at the even address
        for (int w = 0; w < 2048; w++) begin
            shadow[w] = {u_sram_drv.mem[2*w+1], u_sram_drv.mem[2*w]};
        end

        // Full write then read back
        do_write(32'h40, $urandom(), STRB_ALL);
        do_read(32'h40);

        // Untouched word must come back from the fill
        do_read(32'h604);

        // Partial writes go through read-modify-write
        for (int i = 0; i < 4; i++) begin
            a = 32'h80 + 32'(4 * i);
            do_write(a, $urandom(), STRB_ALL);
            do_write(a, $urandom(), strb_t'($urandom_range(14, 0)));
            do_read(a);
        end

        // CRC over five words with an unaligned end and then over a single word
        for (int i = 0; i < 5; i++) begin
            do_write(32'h200 + 32'(4 * i), $urandom(), STRB_ALL);
        end
        do_crc(32'h200, 32'h212);
        do_write(32'h300, $urandom(), STRB_ALL);
        do_crc(32'h300, 32'h300);

        // Unknown code keeps the last result
        issue(cmd_e'(8'h33), $urandom(), $urandom(), '0);
        wait_done("unknown command");
        next_cycle();

        // Start during a CRC is dropped and the shadow stays as it is
        do_write(32'h400, $urandom(), STRB_ALL);
        exp_result = ref_crc(32'h200, 32'h212);
        issue(CMD_CRC, 32'h200, 32'h212, '0);
        next_cycle();
        assert (busy) else abort_run($sformatf(
            "error: busy = %h when the second start was issued, expected 1", busy));
        issue(CMD_WRITE, 32'h400, $urandom(), STRB_ALL);
        wait_done("CRC with an ignored start");
        next_cycle();
        do_read(32'h400);

        next_cycle();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: verification/sram_drv_model.sv
`timescale 1ns/1ps

module sram_drv_model import sram_proc_pkg::*; #(
    parameter int ADDR_W = 19
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              sram_valid,
    input  logic              sram_we,
    input  logic [ADDR_W-1:0] sram_addr,
    input  half_t             sram_wdata,
    output logic              sram_ready,
    output half_t             sram_rdata
);

    // 4096 half-words, upper address bits ignored
    half_t       mem [0:4095];
    logic [1:0]  wait_cnt;
    logic [11:0] idx;

    assign idx = sram_addr[11:0];

    // Fill pattern built from every address bit
    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = half_t'(i * 40503) ^ 16'hC3A5;
        end
    end

    // Ready comes two cycles after valid rises, for one cycle
    always @(posedge clk) begin
        if (!resetn) begin
            wait_cnt   <= '0;
            sram_ready <= 1'b0;
            sram_rdata <= '0;
        end else begin
            sram_ready <= 1'b0;
            if (sram_valid && !sram_ready) begin
                if (wait_cnt == 2'd1) begin
                    wait_cnt   <= '0;
                    sram_ready <= 1'b1;
                    // Write lands on ready, read data shows in the same cycle
                    if (sram_we) begin
                        mem[idx] <= sram_wdata;
                    end else begin
                        sram_rdata <= mem[idx];
                    end
                end else begin
                    wait_cnt <= wait_cnt + 2'd1;
                end
            end
        end
    end

endmodule

// File: rtl/sram_proc.sv
`timescale 1ns/1ps

module sram_proc import sram_proc_pkg::*; #(
    parameter int SRAM_ADDR_W = 19
) (
    input  logic                   clk,
    input  logic                   resetn,
    // Host command port
    input  logic                   start,
    input  cmd_e                   cmd,
    input  word_t                  addr_in,
    input  word_t                  data_in,
    input  strb_t                  mem_wstrb,
    output logic                   busy,
    output logic                   done,
    output word_t                  result,
    // SRAM driver port
    output logic                   sram_valid,
    output logic                   sram_we,
    output logic [SRAM_ADDR_W-1:0] sram_addr,
    output half_t                  sram_wdata,
    input  logic                   sram_ready,
    input  half_t                  sram_rdata
);

    // Controller to word engine
    logic  word_req;
    logic  word_we;
    word_t word_addr;
    word_t word_wdata;
    strb_t word_wstrb;
    logic  word_ack;
    word_t word_rdata;

    // Controller and scanner
    logic  crc_start;
    word_t crc_first;
    word_t crc_last;
    logic  crc_req;
    word_t crc_addr;
    logic  crc_done;
    word_t crc_value;

    sram_cmd_ctrl u_cmd_ctrl (.*);

    sram_word_engine #(
        .SRAM_ADDR_W (SRAM_ADDR_W)
    ) u_word_engine (.*);

    // Ack and read data go to the scanner as well
    crc32_scanner u_crc_scanner (.*);

endmodule

// File: rtl/sram_cmd_ctrl.sv
`timescale 1ns/1ps

module sram_cmd_ctrl import sram_proc_pkg::*; (
    input  logic  clk,
    input  logic  resetn,
    // Host command port
    input  logic  start,
    input  cmd_e  cmd,
    input  word_t addr_in,
    input  word_t data_in,
    input  strb_t mem_wstrb,
    output logic  busy,
    output logic  done,
    output word_t result,
    // Word engine request
    output logic  word_req,
    output logic  word_we,
    output word_t word_addr,
    output word_t word_wdata,
    output strb_t word_wstrb,
    input  logic  word_ack,
    input  word_t word_rdata,
    // CRC scanner
    output logic  crc_start,
    output word_t crc_first,
    output word_t crc_last,
    input  logic  crc_req,
    input  word_t crc_addr,
    input  logic  crc_done,
    input  word_t crc_value
);

    typedef enum logic [1:0] {
        ST_IDLE, ST_WORD_OP, ST_CRC_OP, ST_FINISH
    } state_e;

    state_e state;
    cmd_e   cmd_q;
    word_t  addr_q;
    word_t  data_q;
    strb_t  strb_q;
    logic   req_q;
    logic   crc_active;

    // ======================================================================
    // Word engine routing, scanner owns it during CRC
    // ======================================================================
    assign crc_active = (state == ST_CRC_OP);
    assign word_req   = crc_active ? crc_req : req_q;
    assign word_we    = !crc_active && (cmd_q == CMD_WRITE);
    assign word_addr  = crc_active ? crc_addr : addr_q;
    assign word_wdata = data_q;
    assign word_wstrb = strb_q;

    // CRC range is start address and end address
    assign crc_first  = addr_q;
    assign crc_last   = data_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state     <= ST_IDLE;
            busy      <= 1'b0;
            done      <= 1'b0;
            result    <= '0;
            req_q     <= 1'b0;
            crc_start <= 1'b0;
        end else begin
            // Single-cycle pulses
            done      <= 1'b0;
            req_q     <= 1'b0;
            crc_start <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start && !busy) begin
                        cmd_q  <= cmd;
                        addr_q <= addr_in;
                        data_q <= data_in;
                        strb_q <= mem_wstrb;
                        case (cmd)
                            CMD_READ, CMD_WRITE: begin
                                req_q <= 1'b1;
                                busy  <= 1'b1;
                                state <= ST_WORD_OP;
                            end
                            CMD_CRC: begin
                                crc_start <= 1'b1;
                                busy      <= 1'b1;
                                state     <= ST_CRC_OP;
                            end
                            // Unknown code, finish at once, result kept
                            default: done <= 1'b1;
                        endcase
                    end
                end
                ST_WORD_OP: begin
                    if (word_ack) begin
                        result <= (cmd_q == CMD_WRITE) ? '0 : word_rdata;
                        state  <= ST_FINISH;
                    end
                end
                ST_CRC_OP: begin
                    if (crc_done) begin
                        result <= crc_value;
                        state  <= ST_FINISH;
                    end
                end
                default: begin
                    done  <= 1'b1;
                    busy  <= 1'b0;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!resetn)
        done |=> !done)
        else $error("done held high for two cycles");

endmodule

// File: rtl/crc32_scanner.sv
`timescale 1ns/1ps

module crc32_scanner import sram_proc_pkg::*; (
    input  logic  clk,
    input  logic  resetn,
    // Range from the command controller
    input  logic  crc_start,
    input  word_t crc_first,
    input  word_t crc_last,
    // Reads through the word engine
    output logic  crc_req,
    output word_t crc_addr,
    input  logic  word_ack,
    input  word_t word_rdata,
    // Result
    output logic  crc_done,
    output word_t crc_value
);

    typedef enum logic [1:0] {
        ST_IDLE, ST_REQUEST, ST_WAIT_WORD, ST_FINISH
    } state_e;

    state_e state;
    word_t  addr_q;
    word_t  last_q;
    word_t  crc_q;
    word_t  next_addr;

    assign next_addr = addr_q + 32'd4;

    // One request per word, issued from the request state
    assign crc_req   = (state == ST_REQUEST);
    assign crc_addr  = addr_q;
    assign crc_done  = (state == ST_FINISH);
    // Final inversion
    assign crc_value = ~crc_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (crc_start) begin
                        addr_q <= crc_first;
                        last_q <= crc_last;
                        crc_q  <= CRC32_INIT;
                        state  <= ST_REQUEST;
                    end
                end
                ST_REQUEST: state <= ST_WAIT_WORD;
                ST_WAIT_WORD: begin
                    if (word_ack) begin
                        crc_q  <= crc32_word(crc_q, word_rdata);
                        addr_q <= next_addr;
                        // Stop once the next word would reach the end address
                        state  <= (next_addr >= last_q) ? ST_FINISH : ST_REQUEST;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // No second read until the first has been acked
    a_one_outstanding: assert property (@(posedge clk) disable iff (!resetn)
        crc_req |=> (!crc_req until_with word_ack))
        else $error("crc_req issued while a read was outstanding");

endmodule

// File: rtl/sram_word_engine.sv
`timescale 1ns/1ps

module sram_word_engine import sram_proc_pkg::*; #(
    parameter int SRAM_ADDR_W = 19
) (
    input  logic                   clk,
    input  logic                   resetn,
    // Word request side
    input  logic                   word_req,
    input  logic                   word_we,
    input  word_t                  word_addr,
    input  word_t                  word_wdata,
    input  strb_t                  word_wstrb,
    output logic                   word_ack,
    output word_t                  word_rdata,
    // SRAM driver side
    output logic                   sram_valid,
    output logic                   sram_we,
    output logic [SRAM_ADDR_W-1:0] sram_addr,
    output half_t                  sram_wdata,
    input  logic                   sram_ready,
    input  half_t                  sram_rdata
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_RMW_LOW, ST_RMW_HIGH, ST_MERGE,
        ST_LOW, ST_GAP, ST_HIGH, ST_COMPLETE
    } state_e;

    state_e state;
    // Access that follows the gap cycle
    state_e gap_next;

    // Latched request, word index only (bits 1:0 dropped)
    logic [SRAM_ADDR_W-2:0] wa_q;
    word_t data_q;
    strb_t strb_q;
    logic  we_q;
    // Read data, also the old word during read-modify-write
    word_t rdata_q;
    word_t merged;

    // New bytes over old ones, lane by lane
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged[8*i +: 8] = strb_q[i] ? data_q[8*i +: 8] : rdata_q[8*i +: 8];
        end
    end

    assign word_ack   = (state == ST_COMPLETE);
    assign word_rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= ST_IDLE;
            gap_next   <= ST_HIGH;
            sram_valid <= 1'b0;
            sram_we    <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (word_req) begin
                        wa_q        <= word_addr[SRAM_ADDR_W:2];
                        data_q      <= word_wdata;
                        strb_q      <= word_wstrb;
                        we_q        <= word_we;
                        // Low half-word goes out first
                        sram_addr   <= {word_addr[SRAM_ADDR_W:2], 1'b0};
                        sram_wdata  <= word_wdata[15:0];
                        sram_valid  <= 1'b1;
                        if (word_we && word_wstrb != STRB_ALL) begin
                            // Partial write, fetch old word first
                            sram_we <= 1'b0;
                            state   <= ST_RMW_LOW;
                        end else begin
                            sram_we <= word_we;
                            state   <= ST_LOW;
                        end
                    end
                end
                ST_RMW_LOW: begin
                    if (sram_ready) begin
                        rdata_q[15:0] <= sram_rdata;
                        sram_valid    <= 1'b0;
                        gap_next      <= ST_RMW_HIGH;
                        state         <= ST_GAP;
                    end
                end
                ST_RMW_HIGH: begin
                    if (sram_ready) begin
                        rdata_q[31:16] <= sram_rdata;
                        sram_valid     <= 1'b0;
                        state          <= ST_MERGE;
                    end
                end
                ST_MERGE: begin
                    // Valid low here, so this cycle doubles as the gap
                    data_q     <= merged;
                    sram_addr  <= {wa_q, 1'b0};
                    sram_wdata <= merged[15:0];
                    sram_we    <= 1'b1;
                    sram_valid <= 1'b1;
                    state      <= ST_LOW;
                end
                ST_LOW: begin
                    if (sram_ready) begin
                        rdata_q[15:0] <= sram_rdata;
                        sram_valid    <= 1'b0;
                        sram_we       <= 1'b0;
                        gap_next      <= ST_HIGH;
                        state         <= ST_GAP;
                    end
                end
                ST_GAP: begin
                    // Set up the high half-word access
                    sram_addr  <= {wa_q, 1'b1};
                    sram_wdata <= data_q[31:16];
                    sram_we    <= we_q && (gap_next == ST_HIGH);
                    sram_valid <= 1'b1;
                    state      <= gap_next;
                end
                ST_HIGH: begin
                    if (sram_ready) begin
                        rdata_q[31:16] <= sram_rdata;
                        sram_valid     <= 1'b0;
                        sram_we        <= 1'b0;
                        state          <= ST_COMPLETE;
                    end
                end
                default: begin
                    // Ack cycle
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Driver sees a frozen access until it answers
    a_hold_stable: assert property (@(posedge clk) disable iff (!resetn)
        sram_valid && !sram_ready |=>
            $stable(sram_addr) && $stable(sram_we) && $stable(sram_wdata))
        else $error("SRAM access changed while waiting for ready");

    // At least one idle cycle after each access
    a_valid_gap: assert property (@(posedge clk) disable iff (!resetn)
        sram_valid && sram_ready |=> !sram_valid)
        else $error("sram_valid high in the cycle after ready");

endmodule

// File: rtl/sram_proc_pkg.sv
package sram_proc_pkg;

    // ======================================================================
    // Common data types
    // ======================================================================

    // 32-bit data word or byte address
    typedef logic [31:0] word_t;
    // One SRAM half-word
    typedef logic [15:0] half_t;
    // Byte lane strobes, bit n covers byte n
    typedef logic [3:0]  strb_t;

    // Host command codes
    typedef enum logic [7:0] {
        CMD_NONE  = 8'h00,
        CMD_READ  = 8'h01,
        CMD_WRITE = 8'h02,
        CMD_CRC   = 8'h04
    } cmd_e;

    // All four lanes set, full word write
    localparam strb_t STRB_ALL = 4'hF;

    // ======================================================================
    // CRC-32, reflected Ethernet polynomial
    // ======================================================================
    localparam word_t CRC32_POLY = 32'hEDB88320;
    localparam word_t CRC32_INIT = 32'hFFFFFFFF;

    // Fold one word into the running CRC, LSB first
    function automatic word_t crc32_word(input word_t crc, input word_t data);
        word_t c;
        c = crc;
        for (int i = 0; i < 32; i++) begin
            // Shift out one bit, apply polynomial on mismatch
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ CRC32_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage
